//--- hdl/mem_sys_pkg.sv
`default_nettype none

package mem_sys_pkg;

  ////////////////////////////////
  // Bus widths
  ////////////////////////////////
  localparam int DATA_WIDTH = 32;
  localparam int ADDR_WIDTH = 32;        // Byte address
  localparam int DMEM_AW    = 10;        // 1024 words, 0x0000..0x0FFF

  // Access size codes, code 3 is illegal
  localparam logic [1:0] SIZE_WORD = 2'd0;
  localparam logic [1:0] SIZE_BYTE = 2'd1;
  localparam logic [1:0] SIZE_HALF = 2'd2;

  ////////////////////////////////
  // Memory map
  ////////////////////////////////
  localparam logic [ADDR_WIDTH-1:0] ADDR_MMIO_BASE  = 32'h0000_C000;
  localparam int                    MMIO_WIN_AW     = 4;   // 16 byte window
  localparam logic [ADDR_WIDTH-1:0] ADDR_PS2_CHAR   = 32'h0000_C000;
  localparam logic [ADDR_WIDTH-1:0] ADDR_PS2_STATUS = 32'h0000_C004;
  localparam logic [ADDR_WIDTH-1:0] ADDR_CONFIG     = 32'h0000_C008;
  localparam logic [ADDR_WIDTH-1:0] ADDR_TIMER      = 32'h0000_C00C;

  // PS/2 status bits, the rest read zero
  localparam int ST_READY      = 0;
  localparam int ST_BREAK      = 1;
  localparam int ST_EXTENDED   = 2;
  localparam int ST_PARITY_ERR = 3;

endpackage

`default_nettype wire

//--- hdl/mem_port_if.sv
`default_nettype none

// One request/response port, request in cycle N, rdata in N+1
interface mem_port_if
  import mem_sys_pkg::*;
();

  logic [ADDR_WIDTH-1:0] addr;
  logic                  wr;     // Write strobe
  logic                  rd;     // Read strobe
  logic [1:0]            size;   // SIZE_* code
  logic [DATA_WIDTH-1:0] wdata;
  logic [DATA_WIDTH-1:0] rdata;  // Valid one cycle after rd

  // Decoder side
  modport host (
    output addr, wr, rd, size, wdata,
    input  rdata
  );

  // Memory or peripheral side
  modport target (
    input  addr, wr, rd, size, wdata,
    output rdata
  );

endinterface

`default_nettype wire

//--- hdl/lane_align.sv
`default_nettype none

module lane_align
  import mem_sys_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  mem_port_if.target              req,
  output logic [DMEM_AW-1:0]      ram_addr_o,
  output logic [DATA_WIDTH/8-1:0] ram_be_o,
  output logic [DATA_WIDTH-1:0]   ram_wdata_o,
  input  logic [DATA_WIDTH-1:0]   ram_rdata_i
);

  // Big-endian lanes
  // offset 0 -> [31:24], 1 -> [23:16], 2 -> [15:8], 3 -> [7:0]
  function automatic logic [4:0] lane_shift(input logic [1:0] size, input logic [1:0] off);
    case (size)
      SIZE_BYTE: lane_shift = {~off, 3'b000};                  // 24,16,8,0
      SIZE_HALF: lane_shift = {(2'd2 - off), 3'b000};          // 16,8,0
      default:   lane_shift = 5'd0;
    endcase
  endfunction

  logic [1:0]            off;
  logic [4:0]            st_shift;
  logic [DATA_WIDTH/8-1:0] be;
  logic [1:0]            off_q;    // Load offset, lines up with RAM read
  logic [1:0]            size_q;
  logic [4:0]            ld_shift;
  logic [DATA_WIDTH-1:0] ld_word;

  assign off        = req.addr[1:0];
  assign st_shift   = lane_shift(req.size, off);
  assign ram_addr_o = req.addr[DMEM_AW+1:2];   // Word address

  ////////////////////////////////
  // Store side
  ////////////////////////////////
  always_comb begin
    case (req.size)
      SIZE_BYTE: begin
        be          = 4'b1000 >> off;
        ram_wdata_o = {{(DATA_WIDTH-8){1'b0}}, req.wdata[7:0]} << st_shift;
      end
      SIZE_HALF: begin
        be          = 4'b1100 >> off;
        ram_wdata_o = {{(DATA_WIDTH-16){1'b0}}, req.wdata[15:0]} << st_shift;
      end
      default: begin               // Full word, offset ignored
        be          = 4'b1111;
        ram_wdata_o = req.wdata;
      end
    endcase
  end

  assign ram_be_o = req.wr ? be : '0;   // No write unless strobed

  ////////////////////////////////
  // Load side
  ////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      off_q  <= 2'd0;
      size_q <= SIZE_WORD;
    end else begin
      off_q  <= off;
      size_q <= req.size;
    end
  end

  assign ld_shift = lane_shift(size_q, off_q);
  assign ld_word  = ram_rdata_i >> ld_shift;

  always_comb begin
    case (size_q)
      SIZE_BYTE: req.rdata = {{(DATA_WIDTH-8){1'b0}}, ld_word[7:0]};    // Zero-extend
      SIZE_HALF: req.rdata = {{(DATA_WIDTH-16){1'b0}}, ld_word[15:0]};
      default:   req.rdata = ram_rdata_i;
    endcase
  end

  // Size code 3 never reaches the RAM
  a_no_size3: assert property (@(posedge clk) disable iff (!rst_n)
    (req.wr || req.rd) |-> req.size != 2'd3);

  // Half word would straddle two RAM words
  a_no_half_off3: assert property (@(posedge clk) disable iff (!rst_n)
    (req.wr || req.rd) |-> !(req.size == SIZE_HALF && off == 2'd3));

endmodule

`default_nettype wire

//--- hdl/dmem.sv
`default_nettype none

module dmem
  import mem_sys_pkg::*;
(
  input  logic                    clk,
  input  logic [DMEM_AW-1:0]      addr_i,   // Word address
  input  logic [DATA_WIDTH/8-1:0] be_i,     // be_i[3] is the high byte
  input  logic [DATA_WIDTH-1:0]   wdata_i,
  output logic [DATA_WIDTH-1:0]   rdata_o
);

  logic [DATA_WIDTH-1:0] mem [2**DMEM_AW];

  ////////////////////////////////
  // Byte-enabled write
  ////////////////////////////////
  always_ff @(posedge clk) begin
    for (int b = 0; b < DATA_WIDTH/8; b++) begin
      if (be_i[b]) begin
        mem[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
      end
    end
  end

  // Read every cycle, old data on a same-cycle write
  always_ff @(posedge clk) begin
    rdata_o <= mem[addr_i];
  end

endmodule

`default_nettype wire

//--- hdl/ps2_rx.sv
`default_nettype none

module ps2_rx (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       ps2_clk_i,     // Keyboard clock, async
  input  logic       ps2_dat_i,
  output logic [7:0] key_o,
  output logic       key_valid_o,   // One cycle per reported key
  output logic       break_o,       // Key was preceded by F0
  output logic       extended_o,    // Key was preceded by E0
  output logic       parity_err_o
);

  logic [2:0]  clk_sync;   // Two sync stages plus one for edge detect
  logic [1:0]  dat_sync;
  logic        fall;
  logic [3:0]  bit_cnt;
  logic [9:0]  shreg;      // Bits received so far, LSB first
  logic [10:0] frame;      // Stop, parity, data, start
  logic        frame_done;
  logic        par_ok;
  logic [7:0]  code;
  logic        brk_pend;
  logic        ext_pend;

  ////////////////////////////////
  // Synchronisers
  ////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      clk_sync <= 3'b111;   // Lines idle high
      dat_sync <= 2'b11;
    end else begin
      clk_sync <= {clk_sync[1:0], ps2_clk_i};
      dat_sync <= {dat_sync[0], ps2_dat_i};
    end
  end

  assign fall       = clk_sync[2] & ~clk_sync[1];
  assign frame      = {dat_sync[1], shreg};
  assign frame_done = fall && (bit_cnt == 4'd10);
  assign code       = frame[8:1];
  assign par_ok     = ^frame[9:1];   // Odd parity over data and parity bit

  // Data shifts in from the top
  always_ff @(posedge clk) begin
    if (fall) begin
      shreg <= {dat_sync[1], shreg[9:1]};
    end
  end

  ////////////////////////////////
  // Frame and prefix control
  ////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      bit_cnt      <= 4'd0;
      key_o        <= 8'h00;
      key_valid_o  <= 1'b0;
      break_o      <= 1'b0;
      extended_o   <= 1'b0;
      parity_err_o <= 1'b0;
      brk_pend     <= 1'b0;
      ext_pend     <= 1'b0;
    end else begin
      key_valid_o <= 1'b0;
      if (fall) begin
        bit_cnt <= (bit_cnt == 4'd10) ? 4'd0 : bit_cnt + 4'd1;
      end
      if (frame_done) begin
        if (code == 8'hF0) begin
          brk_pend <= 1'b1;          // Release prefix, held for next key
        end else if (code == 8'hE0) begin
          ext_pend <= 1'b1;
        end else begin
          key_o        <= code;      // Reported even on bad parity
          key_valid_o  <= 1'b1;
          break_o      <= brk_pend;
          extended_o   <= ext_pend;
          parity_err_o <= ~par_ok;
          brk_pend     <= 1'b0;
          ext_pend     <= 1'b0;
        end
      end
    end
  end

  a_key_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    key_valid_o |=> !key_valid_o);

endmodule

`default_nettype wire

//--- hdl/mmio_regs.sv
`default_nettype none

module mmio_regs
  import mem_sys_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  mem_port_if.target bus,            // Full-word access only
  input  logic [7:0] key_i,
  input  logic       key_valid_i,
  input  logic       break_i,
  input  logic       extended_i,
  input  logic       parity_err_i,
  output logic [7:0] cfg_o,
  output logic [7:0] key_o
);

  logic [7:0]            key_q;
  logic                  ready_q;
  logic                  brk_q;
  logic                  ext_q;
  logic                  perr_q;
  logic [7:0]            cfg_q;
  logic [DATA_WIDTH-1:0] timer_q;    // Cycles since reset
  logic [DATA_WIDTH-1:0] status;
  logic [DATA_WIDTH-1:0] rdata_q;

  always_comb begin
    status                = '0;
    status[ST_READY]      = ready_q;
    status[ST_BREAK]      = brk_q;
    status[ST_EXTENDED]   = ext_q;
    status[ST_PARITY_ERR] = perr_q;
  end

  ////////////////////////////////
  // Register state
  ////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      key_q   <= 8'h00;
      ready_q <= 1'b0;
      brk_q   <= 1'b0;
      ext_q   <= 1'b0;
      perr_q  <= 1'b0;
      cfg_q   <= 8'h00;
      timer_q <= '0;
    end else begin
      timer_q <= timer_q + 1'b1;
      if (bus.rd && bus.addr == ADDR_PS2_CHAR) begin
        ready_q <= 1'b0;              // Key consumed
      end
      if (key_valid_i) begin          // New key wins over a clear
        key_q   <= key_i;
        brk_q   <= break_i;
        ext_q   <= extended_i;
        perr_q  <= parity_err_i;
        ready_q <= 1'b1;
      end
      if (bus.wr && bus.addr == ADDR_CONFIG) begin
        cfg_q <= bus.wdata[7:0];      // Other writes dropped
      end
    end
  end

  // Read data for the following cycle
  always_ff @(posedge clk) begin
    if (bus.rd) begin
      case (bus.addr)
        ADDR_PS2_CHAR:   rdata_q <= {{(DATA_WIDTH-8){1'b0}}, key_q};
        ADDR_PS2_STATUS: rdata_q <= status;
        ADDR_CONFIG:     rdata_q <= {{(DATA_WIDTH-8){1'b0}}, cfg_q};
        ADDR_TIMER:      rdata_q <= timer_q;
        default:         rdata_q <= '0;
      endcase
    end
  end

  assign bus.rdata = rdata_q;
  assign cfg_o     = cfg_q;
  assign key_o     = key_q;

endmodule

`default_nettype wire

//--- hdl/mem_map.sv
`default_nettype none

module mem_map
  import mem_sys_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [ADDR_WIDTH-1:0] addr_i,
  input  logic                  wr_i,
  input  logic                  rd_i,
  input  logic [1:0]            size_i,
  input  logic [DATA_WIDTH-1:0] wdata_i,
  output logic [DATA_WIDTH-1:0] rdata_o,
  mem_port_if.host              dmem_port,
  mem_port_if.host              mmio_port
);

  logic in_dmem;
  logic in_mmio;
  logic dmem_sel_q;    // Range of last cycle's request
  logic mmio_sel_q;

  ////////////////////////////////
  // Address decode
  ////////////////////////////////
  assign in_dmem = (addr_i[ADDR_WIDTH-1:DMEM_AW+2] == '0);
  assign in_mmio = (addr_i[ADDR_WIDTH-1:MMIO_WIN_AW] ==
                    ADDR_MMIO_BASE[ADDR_WIDTH-1:MMIO_WIN_AW]);

  // Payload to both, strobes only to the selected side
  assign dmem_port.addr  = addr_i;
  assign dmem_port.size  = size_i;
  assign dmem_port.wdata = wdata_i;
  assign dmem_port.wr    = wr_i & in_dmem;
  assign dmem_port.rd    = rd_i & in_dmem;

  assign mmio_port.addr  = addr_i;
  assign mmio_port.size  = size_i;
  assign mmio_port.wdata = wdata_i;
  assign mmio_port.wr    = wr_i & in_mmio;
  assign mmio_port.rd    = rd_i & in_mmio;

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      dmem_sel_q <= 1'b0;
      mmio_sel_q <= 1'b0;
    end else begin
      dmem_sel_q <= in_dmem;
      mmio_sel_q <= in_mmio;
    end
  end

  // Returning data, unmapped reads as zero
  assign rdata_o = dmem_sel_q ? dmem_port.rdata :
                   mmio_sel_q ? mmio_port.rdata : '0;

  a_no_wr_rd: assert property (@(posedge clk) disable iff (!rst_n)
    !(wr_i && rd_i));

endmodule

`default_nettype wire

//--- hdl/mem_sys.sv
`default_nettype none

module mem_sys
  import mem_sys_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [ADDR_WIDTH-1:0] addr_i,
  input  logic                  wr_i,
  input  logic                  rd_i,
  input  logic [1:0]            size_i,
  input  logic [DATA_WIDTH-1:0] wdata_i,
  output logic [DATA_WIDTH-1:0] rdata_o,   // One cycle after rd_i
  input  logic                  ps2_clk_i,
  input  logic                  ps2_dat_i,
  output logic [7:0]            cfg_o,
  output logic [7:0]            key_o
);

  ////////////////////////////////
  // Internal links
  ////////////////////////////////
  mem_port_if dmem_port ();
  mem_port_if mmio_port ();

  logic [DMEM_AW-1:0]      ram_addr;
  logic [DATA_WIDTH/8-1:0] ram_be;
  logic [DATA_WIDTH-1:0]   ram_wdata;
  logic [DATA_WIDTH-1:0]   ram_rdata;
  logic [7:0]              ps2_key;
  logic                    ps2_key_valid;
  logic                    ps2_break;
  logic                    ps2_extended;
  logic                    ps2_parity_err;

  mem_map u_mem_map (
    .clk(clk), .rst_n(rst_n),
    .addr_i(addr_i), .wr_i(wr_i), .rd_i(rd_i),
    .size_i(size_i), .wdata_i(wdata_i), .rdata_o(rdata_o),
    .dmem_port(dmem_port.host), .mmio_port(mmio_port.host)
  );

  lane_align u_lane_align (
    .clk(clk), .rst_n(rst_n),
    .req(dmem_port.target),
    .ram_addr_o(ram_addr), .ram_be_o(ram_be),
    .ram_wdata_o(ram_wdata), .ram_rdata_i(ram_rdata)
  );

  dmem u_dmem (
    .clk(clk), .addr_i(ram_addr), .be_i(ram_be),
    .wdata_i(ram_wdata), .rdata_o(ram_rdata)
  );

  mmio_regs u_mmio_regs (
    .clk(clk), .rst_n(rst_n),
    .bus(mmio_port.target),
    .key_i(ps2_key), .key_valid_i(ps2_key_valid),
    .break_i(ps2_break), .extended_i(ps2_extended), .parity_err_i(ps2_parity_err),
    .cfg_o(cfg_o), .key_o(key_o)
  );

  ps2_rx u_ps2_rx (
    .clk(clk), .rst_n(rst_n),
    .ps2_clk_i(ps2_clk_i), .ps2_dat_i(ps2_dat_i),
    .key_o(ps2_key), .key_valid_o(ps2_key_valid),
    .break_o(ps2_break), .extended_o(ps2_extended), .parity_err_o(ps2_parity_err)
  );

endmodule

`default_nettype wire

//--- tests/mem_sys_checker.sv
`default_nettype none

module mem_sys_checker
  import mem_sys_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [ADDR_WIDTH-1:0] addr_i,
  input  logic                  wr_i,
  input  logic                  rd_i,
  input  logic [1:0]            size_i,
  input  logic [DATA_WIDTH-1:0] wdata_i,
  input  logic [DATA_WIDTH-1:0] rdata_i,   // DUT read data
  input  logic                  ps2_clk_i,
  input  logic                  ps2_dat_i,
  input  logic [7:0]            cfg_i,
  input  logic [7:0]            key_i,
  input  logic [3:0]            test_id_i,
  input  logic                  test_start_i,
  input  logic                  test_done_i,
  output int                    n_pass_o,
  output int                    n_fail_o,
  output int                    n_err_o
);

  localparam int PRINT_CAP = 20;   // Error lines shown per test

  logic [7:0]            mem_m [0:4*(2**DMEM_AW)-1];   // Byte model, big-endian words
  logic [7:0]            key_m;
  logic [7:0]            cfg_m;
  logic                  ready_m;
  logic                  brk_m;
  logic                  ext_m;
  logic                  perr_m;
  logic [DATA_WIDTH-1:0] timer_m;      // Cycles since reset
  logic                  exp_pend;     // A read returns this cycle
  logic [DATA_WIDTH-1:0] exp_val;
  logic [ADDR_WIDTH-1:0] exp_addr;
  logic [DATA_WIDTH-1:0] exp_cyc;
  logic                  have_timer;
  logic [DATA_WIDTH-1:0] last_timer;
  logic [DATA_WIDTH-1:0] last_cyc;
  // PS/2 line decoder
  logic                  ps2_clk_q;
  int                    bit_m;
  logic [10:0]           frame_m;
  logic [7:0]            code_m;
  logic                  brk_next;
  logic                  ext_next;
  int                    pend_cnt;     // Cycles until the DUT latches the key
  logic [7:0]            pend_key;
  logic                  pend_brk;
  logic                  pend_ext;
  logic                  pend_perr;
  int                    cur_test;
  int                    errs_test;
  int                    printed;

  function automatic string test_name(input int id);
    case (id)
      1:       test_name = "word_rw";
      2:       test_name = "subword_store";
      3:       test_name = "subword_load";
      4:       test_name = "map_cfg_timer";
      5:       test_name = "ps2_keys";
      6:       test_name = "ps2_ready";
      default: test_name = "between_tests";
    endcase
  endfunction

  ////////////////////////////////
  // Model of the address map
  ////////////////////////////////
  function automatic logic [31:0] expected_read(input logic [31:0] a, input logic [1:0] sz);
    logic [11:0] b;
    b = {a[11:2], 2'b00};
    expected_read = '0;                                 // Unmapped reads as zero
    if (a < 32'h1000) begin
      case (sz)
        SIZE_BYTE: expected_read = {24'h0, mem_m[a[11:0]]};
        SIZE_HALF: expected_read = {16'h0, mem_m[a[11:0]], mem_m[a[11:0] + 12'd1]};
        default:   expected_read = {mem_m[b], mem_m[b + 12'd1], mem_m[b + 12'd2], mem_m[b + 12'd3]};
      endcase
    end else if (a == ADDR_PS2_CHAR) begin
      expected_read = {24'h0, key_m};
    end else if (a == ADDR_PS2_STATUS) begin
      expected_read[ST_READY]      = ready_m;
      expected_read[ST_BREAK]      = brk_m;
      expected_read[ST_EXTENDED]   = ext_m;
      expected_read[ST_PARITY_ERR] = perr_m;
    end else if (a == ADDR_CONFIG) begin
      expected_read = {24'h0, cfg_m};
    end else if (a == ADDR_TIMER) begin
      expected_read = timer_m;
    end
  endfunction

  task automatic model_write(input logic [31:0] a, input logic [1:0] sz, input logic [31:0] d);
    logic [11:0] b;
    b = {a[11:2], 2'b00};
    if (a < 32'h1000) begin
      case (sz)
        SIZE_BYTE: mem_m[a[11:0]] = d[7:0];
        SIZE_HALF: begin
          mem_m[a[11:0]]         = d[15:8];     // High byte at the lower address
          mem_m[a[11:0] + 12'd1] = d[7:0];
        end
        default: begin
          mem_m[b]         = d[31:24];
          mem_m[b + 12'd1] = d[23:16];
          mem_m[b + 12'd2] = d[15:8];
          mem_m[b + 12'd3] = d[7:0];
        end
      endcase
    end else if (a == ADDR_CONFIG) begin
      cfg_m = d[7:0];
    end
  endtask

  task automatic report_value(input string what, input logic [31:0] exp_v,
                              input logic [31:0] act_v);
    errs_test++;
    n_err_o++;
    if (printed < PRINT_CAP) begin
      $display("[ERROR] %s %s: expected %h, actual %h", test_name(cur_test), what, exp_v, act_v);
      printed++;
    end
  endtask

  ////////////////////////////////
  // Per-cycle compare and update
  ////////////////////////////////
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      key_m      = 8'h00;
      cfg_m      = 8'h00;
      ready_m    = 1'b0;
      brk_m      = 1'b0;
      ext_m      = 1'b0;
      perr_m     = 1'b0;
      timer_m    = '0;
      exp_pend   = 1'b0;
      have_timer = 1'b0;
      ps2_clk_q  = 1'b1;   // Idle line
      bit_m      = 0;
      brk_next   = 1'b0;
      ext_next   = 1'b0;
      pend_cnt   = 0;
      cur_test   = 0;
      errs_test  = 0;
      printed    = 0;
      n_pass_o   = 0;
      n_fail_o   = 0;
      n_err_o    = 0;
    end else begin
      // Outputs hold the state from before this edge
      if (key_i !== key_m) report_value("key_o", key_m, key_i);
      if (cfg_i !== cfg_m) report_value("cfg_o", cfg_m, cfg_i);

      if (exp_pend) begin
        if (rdata_i !== exp_val) report_value($sformatf("read %h", exp_addr), exp_val, rdata_i);
        if (exp_addr == ADDR_TIMER && cur_test == 4) begin
          if (have_timer && (rdata_i - last_timer) !== (exp_cyc - last_cyc)) begin
            report_value("timer delta", exp_cyc - last_cyc, rdata_i - last_timer);
          end
          have_timer = 1'b1;
          last_timer = rdata_i;
          last_cyc   = exp_cyc;
        end
      end
      exp_pend = rd_i;
      if (rd_i) begin
        exp_val  = expected_read(addr_i, size_i);
        exp_addr = addr_i;
        exp_cyc  = timer_m;
      end

      if (wr_i) model_write(addr_i, size_i, wdata_i);
      if (rd_i && addr_i == ADDR_PS2_CHAR) ready_m = 1'b0;   // Key consumed

      // Decoded key reaches the registers three edges after the fall
      if (pend_cnt != 0) begin
        pend_cnt--;
        if (pend_cnt == 0) begin
          key_m   = pend_key;
          brk_m   = pend_brk;
          ext_m   = pend_ext;
          perr_m  = pend_perr;
          ready_m = 1'b1;          // Wins over a same-edge clear
        end
      end

      if (ps2_clk_q && !ps2_clk_i) begin      // Falling PS/2 clock
        frame_m[bit_m] = ps2_dat_i;
        if (bit_m == 10) begin
          bit_m  = 0;
          code_m = frame_m[8:1];
          if (code_m == 8'hF0) begin
            brk_next = 1'b1;
          end else if (code_m == 8'hE0) begin
            ext_next = 1'b1;
          end else begin
            pend_key  = code_m;
            pend_brk  = brk_next;
            pend_ext  = ext_next;
            pend_perr = ~^frame_m[9:1];       // Odd parity over data and parity
            pend_cnt  = 3;
            brk_next  = 1'b0;
            ext_next  = 1'b0;
          end
        end else begin
          bit_m++;
        end
      end
      ps2_clk_q = ps2_clk_i;
      timer_m   = timer_m + 1;

      if (test_start_i) begin
        cur_test   = test_id_i;
        errs_test  = 0;
        printed    = 0;
        have_timer = 1'b0;
      end
      if (test_done_i) begin
        $display("test %0d %s: %s (%0d errors)", cur_test, test_name(cur_test),
                 (errs_test == 0) ? "pass" : "fail", errs_test);
        if (errs_test == 0) n_pass_o++;
        else n_fail_o++;
        cur_test  = 0;
        errs_test = 0;
      end
    end
  end

endmodule

`default_nettype wire

//--- tests/mem_sys_tb.sv
`default_nettype none

module mem_sys_tb
  import mem_sys_pkg::*;
();

  localparam int SEED       = 83;
  localparam int PS2_HALF   = 8;    // Half of the 16 clk PS/2 bit
  localparam int N_WORDS    = 64;   // Data memory region under test
  localparam int N_OPS      = 64;
  localparam int N_KEYS     = 12;
  localparam int POLL_LIMIT = 40;
  localparam int NUM_TESTS  = 6;

  logic                  clk;
  logic                  rst_n;
  logic [ADDR_WIDTH-1:0] addr;
  logic                  wr;
  logic                  rd;
  logic [1:0]            size;
  logic [DATA_WIDTH-1:0] wdata;
  logic [DATA_WIDTH-1:0] rdata;
  logic                  ps2_clk;
  logic                  ps2_dat;
  logic [7:0]            cfg;
  logic [7:0]            key;
  logic [3:0]            test_id;
  logic                  test_start;
  logic                  test_done;
  int                    n_pass;
  int                    n_fail;
  int                    n_err;

  always #4 clk = ~clk;

  mem_sys dut0 (
    .clk(clk), .rst_n(rst_n),
    .addr_i(addr), .wr_i(wr), .rd_i(rd), .size_i(size), .wdata_i(wdata),
    .rdata_o(rdata),
    .ps2_clk_i(ps2_clk), .ps2_dat_i(ps2_dat),
    .cfg_o(cfg), .key_o(key)
  );

  mem_sys_checker chk0 (
    .clk(clk), .rst_n(rst_n),
    .addr_i(addr), .wr_i(wr), .rd_i(rd), .size_i(size), .wdata_i(wdata),
    .rdata_i(rdata), .ps2_clk_i(ps2_clk), .ps2_dat_i(ps2_dat),
    .cfg_i(cfg), .key_i(key),
    .test_id_i(test_id), .test_start_i(test_start), .test_done_i(test_done),
    .n_pass_o(n_pass), .n_fail_o(n_fail), .n_err_o(n_err)
  );

  ////////////////////////////////
  // Bus drivers with one request per cycle
  ////////////////////////////////
  task automatic drive_idle();
    @(posedge clk);
    wr <= 1'b0;
    rd <= 1'b0;
  endtask

  task automatic drive_write(input logic [31:0] a, input logic [1:0] sz, input logic [31:0] d);
    @(posedge clk);
    addr  <= a;
    size  <= sz;
    wdata <= d;
    wr    <= 1'b1;
    rd    <= 1'b0;
  endtask

  task automatic drive_read(input logic [31:0] a, input logic [1:0] sz);
    @(posedge clk);
    addr <= a;
    size <= sz;
    wr   <= 1'b0;
    rd   <= 1'b1;
  endtask

  // Data is on rdata in the cycle after the request
  task automatic read_value(input logic [31:0] a, output logic [31:0] d);
    drive_read(a, SIZE_WORD);
    drive_idle();
    @(posedge clk);
    d = rdata;
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $finish;
  endtask

  task automatic wait_key_ready();
    logic [31:0] st;
    int          polls;
    st    = '0;
    polls = 0;
    while (!st[ST_READY] && polls < POLL_LIMIT) begin
      read_value(ADDR_PS2_STATUS, st);
      polls++;
    end
    if (!st[ST_READY]) abort_run("timeout: PS/2 ready bit never came up after a frame");
  endtask

  // Start bit then 8 data bits LSB first then odd parity and stop
  task automatic send_frame(input logic [7:0] code, input logic bad_par);
    logic [10:0] bits;
    bits = {1'b1, (~^code) ^ bad_par, code, 1'b0};
    @(posedge clk);
    for (int i = 0; i < 11; i++) begin
      ps2_dat <= bits[i];                  // Changes while PS/2 clock is high
      repeat (PS2_HALF) @(posedge clk);
      ps2_clk <= 1'b0;
      repeat (PS2_HALF) @(posedge clk);
      ps2_clk <= 1'b1;
    end
    ps2_dat <= 1'b1;
    repeat (4 * PS2_HALF) @(posedge clk);  // Idle gap
  endtask

  task automatic begin_test(input int id);
    @(posedge clk);
    test_id    <= id;
    test_start <= 1'b1;
    @(posedge clk);
    test_start <= 1'b0;
  endtask

  task automatic end_test();
    drive_idle();
    repeat (2) @(posedge clk);             // Last read has returned
    test_done <= 1'b1;
    @(posedge clk);
    test_done <= 1'b0;
  endtask

  // Random legal sub-word address inside the region
  function automatic logic [31:0] sub_addr(input logic [1:0] sz);
    logic [31:0] w;
    w = $urandom_range(0, N_WORDS - 1) * 4;
    sub_addr = w + ((sz == SIZE_HALF) ? $urandom_range(0, 2) : $urandom_range(0, 3));
  endfunction

  ////////////////////////////////
  // Test sequence
  ////////////////////////////////
  initial begin
    int          order [N_WORDS];
    int          j;
    int          tmp;
    int          k;
    logic [1:0]  sz;
    logic [1:0]  pfx;
    logic [7:0]  code;

    clk        = 1'b0;
    rst_n      = 1'b0;
    addr       = '0;
    wr         = 1'b0;
    rd         = 1'b0;
    size       = SIZE_WORD;
    wdata      = '0;
    ps2_clk    = 1'b1;
    ps2_dat    = 1'b1;
    test_id    = '0;
    test_start = 1'b0;
    test_done  = 1'b0;
    void'($urandom(SEED));
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;

    // Test 1 writes full words and reads them back shuffled
    begin_test(1);
    for (int w = 0; w < N_WORDS; w++) drive_write(w * 4, SIZE_WORD, $urandom());
    for (int w = 0; w < N_WORDS / 2; w++) begin
      drive_write($urandom_range(0, N_WORDS - 1) * 4, SIZE_WORD, $urandom());
    end
    for (int w = 0; w < N_WORDS; w++) order[w] = w;
    for (int w = N_WORDS - 1; w > 0; w--) begin
      j        = $urandom_range(0, w);
      tmp      = order[w];
      order[w] = order[j];
      order[j] = tmp;
    end
    for (int w = 0; w < N_WORDS; w++) drive_read(order[w] * 4, SIZE_WORD);
    end_test();

    // Test 2 merges byte and half stores and checks them by word reads
    begin_test(2);
    for (int n = 0; n < N_OPS; n++) begin
      sz = $urandom_range(0, 1) ? SIZE_BYTE : SIZE_HALF;
      drive_write(sub_addr(sz), sz, $urandom());   // Upper wdata bits are junk
    end
    for (int w = 0; w < N_WORDS; w++) drive_read(w * 4, SIZE_WORD);
    end_test();

    // Test 3 covers sub-word loads
    begin_test(3);
    for (int n = 0; n < N_OPS; n++) begin
      sz = $urandom_range(0, 1) ? SIZE_BYTE : SIZE_HALF;
      drive_read(sub_addr(sz), sz);
    end
    end_test();

    // Test 4 covers the unmapped range, config and timer
    begin_test(4);
    drive_read(32'h0000_2000 + $urandom_range(0, 255) * 4, SIZE_WORD);
    drive_read(32'h0001_0000, SIZE_WORD);
    drive_read(ADDR_MMIO_BASE + 32'h10, SIZE_WORD);
    drive_write(32'h0000_1000 + $urandom_range(0, N_WORDS - 1) * 4, SIZE_WORD, $urandom());
    drive_write(ADDR_CONFIG, SIZE_WORD, $urandom());
    drive_write(32'h0001_C008, SIZE_WORD, $urandom());   // Alias of config if decode is short
    drive_write(ADDR_TIMER, SIZE_WORD, $urandom());
    drive_read(ADDR_CONFIG, SIZE_WORD);
    for (int w = 0; w < N_WORDS; w++) drive_read(w * 4, SIZE_WORD);
    for (int n = 0; n < 3; n++) begin
      k = $urandom_range(1, 20);
      drive_read(ADDR_TIMER, SIZE_WORD);
      repeat (k - 1) drive_idle();
      drive_read(ADDR_TIMER, SIZE_WORD);
    end
    end_test();

    // Test 5 sends key frames with prefixes and bad parity
    begin_test(5);
    for (int n = 0; n < N_KEYS; n++) begin
      code = $urandom_range(0, 255);
      if (code == 8'hF0 || code == 8'hE0) code = code ^ 8'h01;
      pfx = $urandom_range(0, 3);
      if (pfx[1]) send_frame(8'hE0, 1'b0);
      if (pfx[0]) send_frame(8'hF0, 1'b0);
      send_frame(code, $urandom_range(0, 3) == 0);
      wait_key_ready();
      drive_read(ADDR_PS2_CHAR, SIZE_WORD);
      drive_read(ADDR_PS2_STATUS, SIZE_WORD);
    end
    end_test();

    // Test 6 checks that ready stays up until the key is read
    begin_test(6);
    for (int n = 0; n < 2; n++) begin
      drive_read(ADDR_PS2_STATUS, SIZE_WORD);
      send_frame($urandom_range(0, 8'hDF), 1'b0);
      wait_key_ready();
      repeat (20) drive_idle();
      drive_read(ADDR_PS2_STATUS, SIZE_WORD);
      drive_read(ADDR_PS2_STATUS, SIZE_WORD);
      drive_read(ADDR_PS2_CHAR, SIZE_WORD);
      drive_read(ADDR_PS2_STATUS, SIZE_WORD);
      drive_read(ADDR_PS2_STATUS, SIZE_WORD);
    end
    end_test();

    repeat (2) @(posedge clk);
    $display("tests passed %0d, failed %0d, value errors %0d", n_pass, n_fail, n_err);
    if (n_fail == 0 && n_err == 0 && n_pass == NUM_TESTS) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
hdl/mem_sys_pkg.sv
hdl/mem_port_if.sv
hdl/lane_align.sv
hdl/dmem.sv
hdl/ps2_rx.sv
hdl/mmio_regs.sv
hdl/mem_map.sv
hdl/mem_sys.sv
tests/mem_sys_checker.sv
tests/mem_sys_tb.sv
